/* design/decodePkg.sv */
/*
 * Decode stage shared types.
 * Micro-op layout, per-lane decode flags and the dispatch record.
 */

package decodePkg;

	// ========================================
	// Opcodes
	// ========================================

	// Only the classes the decode stage cares about are named here
	// Everything else is treated as a plain ALU micro-op downstream
	typedef enum logic [6:0]
	{
		opAlu    = 7'h00,
		opLoad   = 7'h01,
		opStore  = 7'h02,
		opBranch = 7'h03,
		opFence  = 7'h04,
		opNop    = 7'h05
	} opcodeE;

	// Function codes qualifying opFence
	// A fence orders against the whole back end, an atom opens an IRQ window
	localparam logic [6:0] funcFence = 7'd0;
	localparam logic [6:0] funcAtom  = 7'd1;

	// ========================================
	// Micro-op and decode records
	// ========================================

	// One 32-bit micro-op as delivered by the front end
	typedef struct packed
	{
		opcodeE      opcode;
		logic [6:0]  func;
		logic [5:0]  dst;
		logic [11:0] imm;
	} microOpT;

	// Classification of one lane
	// atomLen is the low nibble of imm and only nonzero for atoms
	typedef struct packed
	{
		logic       fence;
		logic       atom;
		logic       isMem;
		logic       isBranch;
		logic [3:0] atomLen;
	} laneFlagsT;

	// What leaves the stage for each lane
	typedef struct packed
	{
		logic      valid;
		microOpT   op;
		laneFlagsT flags;
	} dispatchOpT;

endpackage

/* design/fenceDecode.sv */
/*
 * Fence and atom detector.
 * Flags serializing micro-ops from opcode and function fields.
 */

`timescale 1ns/1ps

module fenceDecode
(
	input  decodePkg::microOpT instr,
	output logic               fence,
	output logic               atom
);

	// Both flags share the opFence opcode, the function field picks which one
	function automatic logic fnIsFence(input decodePkg::microOpT ir);
		case (ir.opcode)
			decodePkg::opFence:
				fnIsFence = (ir.func == decodePkg::funcFence);
			default:
				fnIsFence = 1'b0;
		endcase
	endfunction

	function automatic logic fnIsAtom(input decodePkg::microOpT ir);
		case (ir.opcode)
			decodePkg::opFence:
				fnIsAtom = (ir.func == decodePkg::funcAtom);
			default:
				fnIsAtom = 1'b0;
		endcase
	endfunction

	// Any other function code under opFence is simply neither
	assign fence = fnIsFence(instr);
	assign atom  = fnIsAtom(instr);

endmodule

/* design/decodeLane.sv */
/*
 * Single decode lane.
 * Classifies one micro-op into fence, atom, memory and branch flags.
 */

`timescale 1ns/1ps

module decodeLane
(
	input  decodePkg::microOpT   op,
	output decodePkg::laneFlagsT flags
);

	logic isFence;
	logic isAtom;

	// Serializing ops are recognised by the dedicated fence decoder
	fenceDecode fence_i
	(
		.instr(op),
		.fence(isFence),
		.atom (isAtom)
	);

	// ========================================
	// Lane classification
	// ========================================

	always_comb
	begin
		flags.fence = isFence;
		flags.atom  = isAtom;

		// Loads and stores both go to the memory pipe
		case (op.opcode)
			decodePkg::opLoad,
			decodePkg::opStore:
				flags.isMem = 1'b1;
			default:
				flags.isMem = 1'b0;
		endcase

		flags.isBranch = (op.opcode == decodePkg::opBranch);

		// The window length only has meaning for an atom
		// Forcing it to zero keeps stray imm bits out of the serializer
		if (isAtom)
		begin
			flags.atomLen = op.imm[3:0];
		end
		else
		begin
			flags.atomLen = 4'd0;
		end
	end

endmodule

/* design/groupLatch.sv */
/*
 * Decode stage input register.
 * Holds one micro-op group until the serializer takes it.
 */

`timescale 1ns/1ps

module groupLatch
#(
	parameter int numLanes = 4
)
(
	input  logic                              clk,
	input  logic                              rstN,
	input  logic                              groupValid,
	input  decodePkg::microOpT [numLanes-1:0] groupOps,
	input  logic [numLanes-1:0]               groupMask,
	input  logic                              take,
	output logic                              inReady,
	output logic                              heldValid,
	output decodePkg::microOpT [numLanes-1:0] heldOps,
	output logic [numLanes-1:0]               heldMask
);

	logic accept;

	// Room is available when empty or when the current group leaves this edge
	// This lets a new group follow directly behind the one being taken
	assign inReady = !heldValid || take;
	assign accept  = groupValid && inReady;

	// Occupancy
	always_ff @(posedge clk)
	begin
		if (!rstN)
			heldValid <= 1'b0;
		else if (accept)
			heldValid <= 1'b1;
		else if (take)
			heldValid <= 1'b0;
	end

	// Group payload, only meaningful while heldValid is set
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			heldOps  <= groupOps;
			heldMask <= groupMask;
		end
	end

	// A group stalled behind a fence must not change under the lanes
	aHeldStable: assert property (@(posedge clk) disable iff (!rstN)
		heldValid && !take |=> $stable(heldOps) && $stable(heldMask));

endmodule

/* design/serializeCtrl.sv */
/*
 * Decode stage serializer.
 * Holds fenced groups until the ROB drains, registers the dispatch group
 * and keeps interrupts masked for the window that follows an atom.
 */

`timescale 1ns/1ps

module serializeCtrl
#(
	parameter int numLanes = 4
)
(
	input  logic                                 clk,
	input  logic                                 rstN,
	input  logic                                 heldValid,
	input  decodePkg::microOpT   [numLanes-1:0]  heldOps,
	input  logic [numLanes-1:0]                  heldMask,
	input  decodePkg::laneFlagsT [numLanes-1:0]  laneFlags,
	input  logic                                 robEmpty,
	output logic                                 take,
	output logic                                 dispatchValid,
	output decodePkg::dispatchOpT [numLanes-1:0] dispatchOps,
	output logic                                 irqMask
);

	// Width of a valid-lane count, and a common width for the window arithmetic
	localparam int cntW = $clog2(numLanes + 1);
	localparam int subW = (cntW > 4) ? cntW : 4;

	logic            groupFence;
	logic            atomHit;
	logic [3:0]      atomLen;
	logic [cntW-1:0] validCount;
	logic [cntW-1:0] aboveCount;
	logic [3:0]      atomCount;
	logic [3:0]      nextCount;
	logic            dispatchFence;

	// Window counter never goes below zero
	function automatic logic [3:0] satSub(input logic [3:0] a, input logic [cntW-1:0] b);
		logic [subW-1:0] aW;
		logic [subW-1:0] bW;
		logic [subW-1:0] diff;
		aW = subW'(a);
		bW = subW'(b);
		diff = aW - bW;
		if (bW >= aW)
			satSub = 4'd0;
		else
			satSub = diff[3:0];
	endfunction

	// ========================================
	// Group reduction
	// ========================================

	// One pass over the lanes gives the fence condition, the popcount and
	// the length left over from the highest valid atom
	always_comb
	begin
		groupFence = 1'b0;
		atomHit    = 1'b0;
		atomLen    = 4'd0;
		validCount = '0;
		aboveCount = '0;
		for (int i = 0; i < numLanes; i++)
		begin
			if (heldMask[i])
			begin
				validCount = validCount + 1'b1;
				groupFence = groupFence | laneFlags[i].fence;
				// A later atom restarts the count of ops behind it
				if (laneFlags[i].atom)
				begin
					atomHit    = 1'b1;
					atomLen    = laneFlags[i].atomLen;
					aboveCount = '0;
				end
				else
					aboveCount = aboveCount + 1'b1;
			end
		end
	end

	// Masked-off lanes never stall the group
	assign take = heldValid && (!groupFence || robEmpty);

	// An atom reloads the window, otherwise the group consumes from it
	assign nextCount = atomHit ? satSub(atomLen, aboveCount) : satSub(atomCount, validCount);

	// ========================================
	// Dispatch registers
	// ========================================

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			dispatchValid <= 1'b0;
			atomCount     <= 4'd0;
			irqMask       <= 1'b0;
		end
		else
		begin
			dispatchValid <= take;
			if (take)
			begin
				atomCount <= nextCount;
				irqMask   <= (nextCount != 4'd0);
			end
		end
	end

	// Per-lane payload, qualified by dispatchValid
	always_ff @(posedge clk)
	begin
		if (take)
		begin
			for (int i = 0; i < numLanes; i++)
			begin
				dispatchOps[i].valid <= heldMask[i];
				dispatchOps[i].op    <= heldOps[i];
				dispatchOps[i].flags <= laneFlags[i];
			end
		end
	end

	always_comb
	begin
		dispatchFence = 1'b0;
		for (int i = 0; i < numLanes; i++)
			dispatchFence = dispatchFence | (dispatchOps[i].valid & dispatchOps[i].flags.fence);
	end

	// A fenced group may only leave once the back end had drained
	aFenceOrder: assert property (@(posedge clk) disable iff (!rstN)
		dispatchValid && dispatchFence |-> $past(robEmpty));

	// Interrupts are never held off outside an atomic window
	aIrqWindow: assert property (@(posedge clk) disable iff (!rstN)
		(atomCount == 4'd0) |-> !irqMask);

endmodule

/* design/decodeStage.sv */
/*
 * Superscalar decode stage top level.
 * Group register, parallel decode lanes and the fence/atom serializer.
 */

`timescale 1ns/1ps

module decodeStage
#(
	parameter int numLanes = 4
)
(
	input  logic                                 clk,
	input  logic                                 rstN,
	input  logic                                 groupValid,
	input  decodePkg::microOpT    [numLanes-1:0] groupOps,
	input  logic [numLanes-1:0]                  groupMask,
	input  logic                                 robEmpty,
	output logic                                 inReady,
	output logic                                 dispatchValid,
	output decodePkg::dispatchOpT [numLanes-1:0] dispatchOps,
	output logic                                 irqMask
);

	logic                                heldValid;
	logic                                take;
	decodePkg::microOpT   [numLanes-1:0] heldOps;
	logic [numLanes-1:0]                 heldMask;
	decodePkg::laneFlagsT [numLanes-1:0] laneFlags;

	groupLatch #(.numLanes(numLanes)) latch_i
	(
		.clk       (clk),
		.rstN      (rstN),
		.groupValid(groupValid),
		.groupOps  (groupOps),
		.groupMask (groupMask),
		.take      (take),
		.inReady   (inReady),
		.heldValid (heldValid),
		.heldOps   (heldOps),
		.heldMask  (heldMask)
	);

	// One decoder per slot of the held group
	for (genvar i = 0; i < numLanes; i++)
	begin : gLane
		decodeLane lane_i
		(
			.op   (heldOps[i]),
			.flags(laneFlags[i])
		);
	end

	serializeCtrl #(.numLanes(numLanes)) serial_i
	(
		.clk          (clk),
		.rstN         (rstN),
		.heldValid    (heldValid),
		.heldOps      (heldOps),
		.heldMask     (heldMask),
		.laneFlags    (laneFlags),
		.robEmpty     (robEmpty),
		.take         (take),
		.dispatchValid(dispatchValid),
		.dispatchOps  (dispatchOps),
		.irqMask      (irqMask)
	);

endmodule

/* sim/decodeStageTb.sv */
/*
 * Decode stage testbench.
 * Applies a table of micro-op groups and checks dispatch timing, lane flags
 * and the interrupt window against a reference model.
 */

`timescale 1ns/1ps

module decodeStageTb;

	localparam int numLanes  = 4;
	localparam int numGroups = 15;

	// Short opcode names keep the stimulus table readable
	localparam decodePkg::opcodeE alu = decodePkg::opAlu;
	localparam decodePkg::opcodeE ld  = decodePkg::opLoad;
	localparam decodePkg::opcodeE st  = decodePkg::opStore;
	localparam decodePkg::opcodeE br  = decodePkg::opBranch;
	localparam decodePkg::opcodeE nop = decodePkg::opNop;

	logic                                 clk;
	logic                                 rstN;
	logic                                 groupValid;
	decodePkg::microOpT    [numLanes-1:0] groupOps;
	logic [numLanes-1:0]                  groupMask;
	logic                                 robEmpty;
	logic                                 inReady;
	logic                                 dispatchValid;
	decodePkg::dispatchOpT [numLanes-1:0] dispatchOps;
	logic                                 irqMask;

	decodePkg::microOpT  tblOps   [numGroups][numLanes];
	logic [numLanes-1:0] tblMask  [numGroups];
	int                  tblDelay [numGroups];

	integer seed = 32'h33ef;
	int     edgeCount = 0;
	int     cycleLimit = 1000;
	int     dispatched = 0;
	int     windowCount = 0;
	int     acceptEdge;
	int     maxDelay;
	int     gIdx;
	int     expEdge;
	bit     checking = 1'b0;
	int     pendGroup [$];
	int     pendEdge  [$];

	decodeStage #(.numLanes(numLanes)) dut_i
	(
		.clk          (clk),
		.rstN         (rstN),
		.groupValid   (groupValid),
		.groupOps     (groupOps),
		.groupMask    (groupMask),
		.robEmpty     (robEmpty),
		.inReady      (inReady),
		.dispatchValid(dispatchValid),
		.dispatchOps  (dispatchOps),
		.irqMask      (irqMask)
	);

	always #5 clk = ~clk;

	// ========================================
	// Reporting
	// ========================================

	task automatic stopRun();
		$display(">>> FAIL");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic checkValue(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected)
		begin
			$display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			stopRun();
		end
	endtask

	// ========================================
	// Stimulus builders and reference model
	// ========================================

	// Plain micro-op with random destination and immediate
	function automatic decodePkg::microOpT randOp(input decodePkg::opcodeE opc);
		decodePkg::microOpT u;
		logic [31:0] r;
		r = $random(seed);
		u.opcode = opc;
		u.func   = 7'd0;
		u.dst    = r[5:0];
		u.imm    = r[17:6];
		return u;
	endfunction

	function automatic decodePkg::microOpT fenceOp();
		return '{decodePkg::opFence, decodePkg::funcFence, 6'd0, 12'd0};
	endfunction

	// Upper imm bits are junk so that only the low nibble may reach atomLen
	function automatic decodePkg::microOpT atomOp(input logic [3:0] len);
		return '{decodePkg::opFence, decodePkg::funcAtom, 6'd0, {8'hc3, len}};
	endfunction

	task automatic setGroup(input int g, input decodePkg::microOpT o0, o1, o2, o3,
		input logic [3:0] mask, input int delay);
		tblOps[g]   = '{o0, o1, o2, o3};
		tblMask[g]  = mask;
		tblDelay[g] = delay;
	endtask

	// Class flags as the micro-op format defines them
	function automatic decodePkg::laneFlagsT expectFlags(input decodePkg::microOpT op);
		decodePkg::laneFlagsT f;
		f = '0;
		if (op.opcode == decodePkg::opFence)
		begin
			f.fence = (op.func == decodePkg::funcFence);
			f.atom  = (op.func == decodePkg::funcAtom);
		end
		f.isMem    = (op.opcode == ld) || (op.opcode == st);
		f.isBranch = (op.opcode == br);
		if (f.atom)
			f.atomLen = op.imm[3:0];
		return f;
	endfunction

	function automatic decodePkg::dispatchOpT expectDispatch(input int g, input int lane);
		return '{tblMask[g][lane], tblOps[g][lane], expectFlags(tblOps[g][lane])};
	endfunction

	// Highest valid atom reloads the window, otherwise the group drains it
	task automatic updateWindow(input int g);
		decodePkg::laneFlagsT f;
		int top;
		int above;
		int len;
		top   = -1;
		above = 0;
		len   = 0;
		for (int i = numLanes - 1; i >= 0; i--)
		begin
			f = expectFlags(tblOps[g][i]);
			if (top < 0 && tblMask[g][i] && f.atom)
			begin
				top = i;
				len = int'(f.atomLen);
			end
			else if (top < 0 && tblMask[g][i])
				above++;
		end
		if (top >= 0)
			windowCount = len - above;
		else
			windowCount = windowCount - $countones(tblMask[g]);
		if (windowCount < 0)
			windowCount = 0;
	endtask

	// ========================================
	// Monitor and cycle limit
	// ========================================

	always @(posedge clk)
	begin
		edgeCount <= edgeCount + 1;
		if (edgeCount >= cycleLimit)
		begin
			$display("The expected dispatch never arrived within %0d cycles", cycleLimit);
			stopRun();
		end
	end

	// Outputs are sampled on the falling edge where they are settled
	always @(negedge clk)
	begin
		if (checking && dispatchValid)
		begin
			if (pendGroup.size() == 0)
			begin
				$display("A dispatch appeared with no group in flight");
				stopRun();
			end
			gIdx    = pendGroup.pop_front();
			expEdge = pendEdge.pop_front();
			checkValue("dispatchValid edge", edgeCount, expEdge);
			for (int i = 0; i < numLanes; i++)
				checkValue($sformatf("dispatchOps[%0d]", i), dispatchOps[i], expectDispatch(gIdx, i));
			updateWindow(gIdx);
			dispatched++;
		end
		if (checking)
			checkValue("irqMask", irqMask, windowCount != 0);
	end

	// ========================================
	// Test sequence
	// ========================================

	initial
	begin
		clk        = 1'b0;
		rstN       = 1'b0;
		groupValid = 1'b0;
		groupOps   = '0;
		groupMask  = '0;
		robEmpty   = 1'b0;

		// Lane 0 first; the mask is written lane 3 down to lane 0
		setGroup(0, randOp(alu), randOp(ld), randOp(st), randOp(br), 4'b1111, 0);
		setGroup(1, randOp(nop), randOp(alu), randOp(ld), randOp(st), 4'b1011, 0);
		setGroup(2, randOp(alu), fenceOp(), randOp(ld), randOp(nop), 4'b1101, 0);
		setGroup(3, randOp(ld), fenceOp(), randOp(alu), randOp(st), 4'b1111, 5);
		setGroup(4, atomOp(4'd7), randOp(alu), randOp(ld), randOp(br), 4'b1111, 0);
		setGroup(5, randOp(alu), randOp(alu), randOp(alu), randOp(alu), 4'b1111, 0);
		setGroup(6, randOp(alu), atomOp(4'd2), randOp(ld), randOp(st), 4'b1111, 0);
		setGroup(7, randOp(alu), randOp(nop), atomOp(4'd9), randOp(st), 4'b0111, 0);
		setGroup(8, randOp(alu), randOp(ld), randOp(st), randOp(br), 4'b0011, 0);
		setGroup(9, randOp(br), randOp(br), randOp(br), randOp(br), 4'b1111, 0);
		setGroup(10, randOp(alu), randOp(ld), randOp(st), randOp(nop), 4'b0001, 0);
		setGroup(11, randOp(ld), randOp(st), randOp(alu), randOp(br), 4'b1111, 0);
		setGroup(12, atomOp(4'd3), randOp(alu), atomOp(4'd6), randOp(nop), 4'b1111, 0);
		setGroup(13, fenceOp(), randOp(alu), randOp(alu), randOp(alu), 4'b1111, 2);
		setGroup(14, randOp(alu), randOp(ld), randOp(st), randOp(br), 4'b1111, 0);

		maxDelay = 0;
		for (int g = 0; g < numGroups; g++)
			if (tblDelay[g] > maxDelay)
				maxDelay = tblDelay[g];
		cycleLimit = numGroups * (maxDelay + 4) + 40;

		repeat (16) @(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);
		checkValue("inReady", inReady, 1'b1);
		checkValue("dispatchValid", dispatchValid, 1'b0);
		checkValue("irqMask", irqMask, 1'b0);
		checking = 1'b1;

		// Each group is offered on the edge right after the previous acceptance
		@(posedge clk);
		for (int g = 0; g < numGroups; g++)
		begin
			groupValid <= 1'b1;
			for (int i = 0; i < numLanes; i++)
				groupOps[i] <= tblOps[g][i];
			groupMask <= tblMask[g];
			do
				@(negedge clk);
			while (!inReady);
			acceptEdge = edgeCount;
			pendGroup.push_back(g);
			pendEdge.push_back(acceptEdge + 2 + tblDelay[g]);
			@(posedge clk);
			if (tblDelay[g] > 0)
			begin
				// The back end stays busy, so the fenced group must not move
				groupValid <= 1'b0;
				repeat (tblDelay[g])
				begin
					@(negedge clk);
					checkValue("inReady", inReady, 1'b0);
					@(posedge clk);
				end
				robEmpty <= 1'b1;
				@(posedge clk);
				robEmpty <= 1'b0;
			end
		end
		groupValid <= 1'b0;

		while (dispatched < numGroups)
			@(negedge clk);
		repeat (3) @(negedge clk);
		$display(">>> PASS");
		$finish;
	end

endmodule

/* sources.f */
design/decodePkg.sv
design/fenceDecode.sv
design/decodeLane.sv
design/groupLatch.sv
design/serializeCtrl.sv
design/decodeStage.sv
sim/decodeStageTb.sv

/* Bender.yml */
package:
  name: decodeStage

sources:
  - files:
      - design/decodePkg.sv
      - design/fenceDecode.sv
      - design/decodeLane.sv
      - design/groupLatch.sv
      - design/serializeCtrl.sv
      - design/decodeStage.sv
  - target: simulation
    files:
      - sim/decodeStageTb.sv
